// ==== verilog/conv_cfg_pkg.sv ====
package conv_cfg_pkg;

    localparam int DATA_W   = 16;    // Pixel, weight and payload width.
    localparam int STRIDE_W = 4;
    localparam int ROWS_W   = 4;

    typedef enum logic [1:0] {
        KIND_CFG    = 2'd0,
        KIND_WEIGHT = 2'd1,
        KIND_PIXEL  = 2'd2
    } beat_kind_e;

    typedef struct packed {
        logic [STRIDE_W-1:0]               stride;
        logic [ROWS_W-1:0]                 num_rows;
        logic [DATA_W-STRIDE_W-ROWS_W-1:0] pad;     // Reserved.
    } frame_cfg_t;

    // Payload of one input beat, read according to the beat kind.
    typedef union packed {
        logic signed [DATA_W-1:0] value;
        frame_cfg_t               cfg;
    } payload_u;

endpackage

// ==== verilog/conv_stream_pkg.sv ====
package conv_stream_pkg;

    localparam int SUM_W = 2 * conv_cfg_pkg::DATA_W + 4;    // Accumulator width.

    typedef struct packed {
        conv_cfg_pkg::beat_kind_e kind;
        logic                     last;     // Final pixel of a row.
        conv_cfg_pkg::payload_u   payload;
    } in_beat_t;

    typedef struct packed {
        logic [conv_cfg_pkg::ROWS_W-1:0] row;
        logic signed [SUM_W-1:0]         sum;
    } psum_t;

endpackage

// ==== verilog/ifmap_loader.sv ====
module ifmap_loader #(
    parameter int IFMAP_DEPTH = 32,
    parameter int MAX_ROW     = 4,
    parameter int FILTER_SIZE = 3,
    localparam int ADDR_W     = (IFMAP_DEPTH > 1) ? $clog2(IFMAP_DEPTH) : 1,
    localparam int ROW_W      = (MAX_ROW > 1) ? $clog2(MAX_ROW) : 1,
    localparam int IDX_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  conv_stream_pkg::in_beat_t              in_beat,
    output logic                                   wr_en,
    output logic [ADDR_W-1:0]                      wr_addr,
    output logic signed [conv_cfg_pkg::DATA_W-1:0] wr_data,
    output logic                                   w_we,
    output logic [IDX_W-1:0]                       w_idx,
    output logic signed [conv_cfg_pkg::DATA_W-1:0] w_data,
    output logic                                   stride_ld,
    output logic [conv_cfg_pkg::STRIDE_W-1:0]      stride,
    output logic                                   tbl_we,
    output logic [ROW_W-1:0]                       tbl_row,
    output logic [ADDR_W-1:0]                      tbl_start,
    output logic [ADDR_W-1:0]                      tbl_end,
    output logic                                   tbl_last,
    output logic                                   frame_loaded,
    input  logic                                   frame_done
);

    logic                            xfer;
    logic [ADDR_W-1:0]               wr_ptr;
    logic [IDX_W-1:0]                w_cnt;
    logic [conv_cfg_pkg::ROWS_W-1:0] row_cnt;
    logic [conv_cfg_pkg::ROWS_W-1:0] num_rows;
    logic [ADDR_W-1:0]               row_start;

    assign in_ready = !frame_loaded;    // Closed while a frame computes.
    assign xfer     = in_valid && in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign stride_ld = xfer && (in_beat.kind == conv_cfg_pkg::KIND_CFG);
    assign stride    = in_beat.payload.cfg.stride;
    assign w_we      = xfer && (in_beat.kind == conv_cfg_pkg::KIND_WEIGHT);
    assign w_idx     = w_cnt;
    assign w_data    = in_beat.payload.value;
    assign wr_en     = xfer && (in_beat.kind == conv_cfg_pkg::KIND_PIXEL);
    assign wr_addr   = wr_ptr;
    assign wr_data   = in_beat.payload.value;

    assign tbl_we    = wr_en && in_beat.last;
    assign tbl_row   = row_cnt[ROW_W-1:0];
    assign tbl_start = row_start;
    assign tbl_end   = wr_ptr + ADDR_W'(1);    // One past the row's last pixel.
    assign tbl_last  = (row_cnt + 1'b1) == num_rows;

    always_ff @(posedge clk) begin
        if (rst || frame_done) begin
            wr_ptr       <= '0;
            w_cnt        <= '0;
            row_cnt      <= '0;
            row_start    <= '0;
            frame_loaded <= 1'b0;
        end else begin
            if (w_we) begin
                w_cnt <= w_cnt + 1'b1;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tbl_we) begin
                row_cnt      <= row_cnt + 1'b1;
                row_start    <= tbl_end;
                frame_loaded <= tbl_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            num_rows <= '0;
        end else if (stride_ld) begin
            num_rows <= in_beat.payload.cfg.num_rows;
        end
    end

endmodule

// ==== verilog/ifmap_spad.sv ====
module ifmap_spad #(
    parameter int IFMAP_DEPTH = 32,
    localparam int ADDR_W     = (IFMAP_DEPTH > 1) ? $clog2(IFMAP_DEPTH) : 1
) (
    input  logic                                   clk,
    input  logic                                   wr_en,
    input  logic [ADDR_W-1:0]                      wr_addr,
    input  logic signed [conv_cfg_pkg::DATA_W-1:0] wr_data,
    input  logic [ADDR_W-1:0]                      raddr,
    output logic signed [conv_cfg_pkg::DATA_W-1:0] rd_data
);

    logic signed [conv_cfg_pkg::DATA_W-1:0] mem [IFMAP_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[raddr];    // Read port is combinational.

endmodule

// ==== verilog/ifmap_addr_gen.sv ====
module ifmap_addr_gen #(
    parameter int IFMAP_DEPTH = 32,
    parameter int MAX_ROW     = 4,
    parameter int FILTER_SIZE = 3,
    localparam int ADDR_W     = (IFMAP_DEPTH > 1) ? $clog2(IFMAP_DEPTH) : 1,
    localparam int ROW_W      = (MAX_ROW > 1) ? $clog2(MAX_ROW) : 1,
    localparam int IDX_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stride_ld,
    input  logic [conv_cfg_pkg::STRIDE_W-1:0] stride,
    input  logic                              tbl_we,
    input  logic [ROW_W-1:0]                  tbl_row,
    input  logic [ADDR_W-1:0]                 tbl_start,
    input  logic [ADDR_W-1:0]                 tbl_end,
    input  logic                              tbl_last,
    input  logic                              head_sel_start,
    input  logic                              head_ld,
    input  logic [IDX_W-1:0]                  offset,
    input  logic                              row_inc,
    input  logic                              row_clr,
    output logic                              row_end,
    output logic                              finish_row,
    output logic [ADDR_W-1:0]                 raddr,
    output logic [ROW_W-1:0]                  row_ptr
);

    logic [ADDR_W-1:0]               head;
    logic [ADDR_W-1:0]               head_next;
    logic [ADDR_W-1:0]               win_end;
    logic [conv_cfg_pkg::STRIDE_W-1:0] stride_q;
    logic [ROW_W-1:0]                last_row;
    logic [ADDR_W-1:0]               start_tbl [MAX_ROW];
    logic [ADDR_W-1:0]               end_tbl   [MAX_ROW];

    assign head_next  = head_sel_start ? start_tbl[row_ptr] : head + ADDR_W'(stride_q);
    assign raddr      = head + ADDR_W'(offset);    // Wraps with the scratchpad.
    assign win_end    = head + ADDR_W'(FILTER_SIZE);
    assign row_end    = (win_end == end_tbl[row_ptr]);
    assign finish_row = (row_ptr == last_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            stride_q <= '0;
            row_ptr  <= '0;
            last_row <= '0;
        end else begin
            if (stride_ld) begin
                stride_q <= stride;
            end
            if (head_ld) begin
                head <= head_next;
            end
            if (row_clr) begin
                row_ptr <= '0;
            end else if (row_inc) begin
                row_ptr <= row_ptr + 1'b1;
            end
            if (tbl_we && tbl_last) begin
                last_row <= tbl_row;
            end
        end
    end

    // Row bounds, written as each row's last pixel lands.
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            start_tbl[tbl_row] <= tbl_start;
            end_tbl[tbl_row]   <= tbl_end;
        end
    end

endmodule

// ==== verilog/conv_ctrl.sv ====
module conv_ctrl #(
    parameter int MAX_ROW     = 4,
    parameter int FILTER_SIZE = 3,
    localparam int ROW_W      = (MAX_ROW > 1) ? $clog2(MAX_ROW) : 1,
    localparam int IDX_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          frame_loaded,
    output logic                                          frame_done,
    output logic                                          head_sel_start,
    output logic                                          head_ld,
    output logic [IDX_W-1:0]                              offset,
    output logic                                          row_inc,
    output logic                                          row_clr,
    input  logic                                          row_end,
    input  logic                                          finish_row,
    input  logic [ROW_W-1:0]                              row_ptr,
    output logic                                          acc_clr,
    output logic                                          acc_en,
    input  logic signed [conv_stream_pkg::SUM_W-1:0]      acc,
    output logic                                          push,
    output conv_stream_pkg::psum_t                        psum_in,
    input  logic                                          full
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ROW_START,
        ST_ACCUM,
        ST_PUSH,
        ST_ADVANCE,
        ST_NEXT_ROW
    } state_e;

    state_e           state;
    state_e           state_next;
    logic [IDX_W-1:0] off_q;
    logic             last_tap;

    assign offset   = off_q;
    assign last_tap = (off_q == IDX_W'(FILTER_SIZE - 1));
    assign push     = (state == ST_PUSH) && !full;

    always_comb begin
        psum_in            = '0;
        psum_in.row[ROW_W-1:0] = row_ptr;    // Tag with the current row.
        psum_in.sum        = acc;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window and row sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next     = state;
        head_sel_start = 1'b0;
        head_ld        = 1'b0;
        row_inc        = 1'b0;
        row_clr        = 1'b0;
        acc_clr        = 1'b0;
        acc_en         = 1'b0;
        frame_done     = 1'b0;
        case (state)
            ST_IDLE: begin
                if (frame_loaded) begin
                    state_next = ST_ROW_START;
                end
            end
            ST_ROW_START: begin
                head_sel_start = 1'b1;    // Head from the row's start entry.
                head_ld        = 1'b1;
                acc_clr        = 1'b1;
                state_next     = ST_ACCUM;
            end
            ST_ADVANCE: begin
                head_ld    = 1'b1;        // Head moves by the stride.
                acc_clr    = 1'b1;
                state_next = ST_ACCUM;
            end
            ST_ACCUM: begin
                acc_en = 1'b1;
                if (last_tap) begin
                    state_next = ST_PUSH;
                end
            end
            ST_PUSH: begin
                if (!full) begin
                    if (!row_end) begin
                        state_next = ST_ADVANCE;
                    end else if (!finish_row) begin
                        state_next = ST_NEXT_ROW;
                    end else begin
                        frame_done = 1'b1;
                        row_clr    = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_NEXT_ROW: begin
                row_inc    = 1'b1;
                state_next = ST_ROW_START;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            off_q <= '0;
        end else begin
            state <= state_next;
            if (state == ST_ACCUM) begin
                off_q <= last_tap ? '0 : off_q + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/mac_unit.sv ====
module mac_unit #(
    parameter int FILTER_SIZE = 3,
    localparam int IDX_W      = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     w_we,
    input  logic [IDX_W-1:0]                         w_idx,
    input  logic signed [conv_cfg_pkg::DATA_W-1:0]   w_data,
    input  logic [IDX_W-1:0]                         offset,
    input  logic signed [conv_cfg_pkg::DATA_W-1:0]   rd_data,
    input  logic                                     acc_clr,
    input  logic                                     acc_en,
    output logic signed [conv_stream_pkg::SUM_W-1:0] acc
);

    logic signed [conv_cfg_pkg::DATA_W-1:0]   weight_q [FILTER_SIZE];
    logic signed [2*conv_cfg_pkg::DATA_W-1:0] prod;

    always_ff @(posedge clk) begin
        if (w_we) begin
            weight_q[w_idx] <= w_data;
        end
    end

    assign prod = weight_q[offset] * rd_data;    // Tap selected by the window offset.

    always_ff @(posedge clk) begin
        if (rst || acc_clr) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + conv_stream_pkg::SUM_W'(prod);    // Sign extends.
        end
    end

endmodule

// ==== verilog/psum_buffer.sv ====
module psum_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  conv_stream_pkg::psum_t psum_in,
    output logic                   full,
    output logic                   psum_valid,
    input  logic                   psum_ready,
    output conv_stream_pkg::psum_t psum
);

    conv_stream_pkg::psum_t mem [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic                   pop;

    assign pop        = psum_valid && psum_ready;
    assign full       = (count == 2'd2);
    assign psum_valid = (count != 2'd0);
    assign psum       = mem[rd_ptr];    // Head entry.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= psum_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

// ==== verilog/conv1d_top.sv ====
module conv1d_top #(
    parameter int IFMAP_DEPTH = 32,
    parameter int MAX_ROW     = 4,
    parameter int FILTER_SIZE = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  conv_stream_pkg::in_beat_t in_beat,
    output logic                      psum_valid,
    input  logic                      psum_ready,
    output conv_stream_pkg::psum_t    psum
);

    localparam int ADDR_W = (IFMAP_DEPTH > 1) ? $clog2(IFMAP_DEPTH) : 1;
    localparam int ROW_W  = (MAX_ROW > 1) ? $clog2(MAX_ROW) : 1;
    localparam int IDX_W  = (FILTER_SIZE > 1) ? $clog2(FILTER_SIZE) : 1;

    logic                                     wr_en;
    logic [ADDR_W-1:0]                        wr_addr;
    logic signed [conv_cfg_pkg::DATA_W-1:0]   wr_data;
    logic                                     w_we;
    logic [IDX_W-1:0]                         w_idx;
    logic signed [conv_cfg_pkg::DATA_W-1:0]   w_data;
    logic                                     stride_ld;
    logic [conv_cfg_pkg::STRIDE_W-1:0]        stride;
    logic                                     tbl_we;
    logic [ROW_W-1:0]                         tbl_row;
    logic [ADDR_W-1:0]                        tbl_start;
    logic [ADDR_W-1:0]                        tbl_end;
    logic                                     tbl_last;
    logic                                     frame_loaded;
    logic                                     frame_done;
    logic                                     head_sel_start;
    logic                                     head_ld;
    logic [IDX_W-1:0]                         offset;
    logic                                     row_inc;
    logic                                     row_clr;
    logic                                     row_end;
    logic                                     finish_row;
    logic [ADDR_W-1:0]                        raddr;
    logic [ROW_W-1:0]                         row_ptr;
    logic signed [conv_cfg_pkg::DATA_W-1:0]   rd_data;
    logic                                     acc_clr;
    logic                                     acc_en;
    logic signed [conv_stream_pkg::SUM_W-1:0] acc;
    logic                                     push;
    conv_stream_pkg::psum_t                   psum_in;
    logic                                     full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ifmap_loader #(
        .IFMAP_DEPTH(IFMAP_DEPTH),
        .MAX_ROW(MAX_ROW),
        .FILTER_SIZE(FILTER_SIZE)
    ) loader_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .w_we(w_we), .w_idx(w_idx), .w_data(w_data),
        .stride_ld(stride_ld), .stride(stride),
        .tbl_we(tbl_we), .tbl_row(tbl_row), .tbl_start(tbl_start),
        .tbl_end(tbl_end), .tbl_last(tbl_last),
        .frame_loaded(frame_loaded), .frame_done(frame_done)
    );

    ifmap_spad #(
        .IFMAP_DEPTH(IFMAP_DEPTH)
    ) spad_i (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .raddr(raddr), .rd_data(rd_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Processing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ifmap_addr_gen #(
        .IFMAP_DEPTH(IFMAP_DEPTH),
        .MAX_ROW(MAX_ROW),
        .FILTER_SIZE(FILTER_SIZE)
    ) addr_gen_i (
        .clk(clk), .rst(rst),
        .stride_ld(stride_ld), .stride(stride),
        .tbl_we(tbl_we), .tbl_row(tbl_row), .tbl_start(tbl_start),
        .tbl_end(tbl_end), .tbl_last(tbl_last),
        .head_sel_start(head_sel_start), .head_ld(head_ld), .offset(offset),
        .row_inc(row_inc), .row_clr(row_clr),
        .row_end(row_end), .finish_row(finish_row),
        .raddr(raddr), .row_ptr(row_ptr)
    );

    conv_ctrl #(
        .MAX_ROW(MAX_ROW),
        .FILTER_SIZE(FILTER_SIZE)
    ) ctrl_i (
        .clk(clk), .rst(rst),
        .frame_loaded(frame_loaded), .frame_done(frame_done),
        .head_sel_start(head_sel_start), .head_ld(head_ld), .offset(offset),
        .row_inc(row_inc), .row_clr(row_clr),
        .row_end(row_end), .finish_row(finish_row), .row_ptr(row_ptr),
        .acc_clr(acc_clr), .acc_en(acc_en), .acc(acc),
        .push(push), .psum_in(psum_in), .full(full)
    );

    mac_unit #(
        .FILTER_SIZE(FILTER_SIZE)
    ) mac_i (
        .clk(clk), .rst(rst),
        .w_we(w_we), .w_idx(w_idx), .w_data(w_data),
        .offset(offset), .rd_data(rd_data),
        .acc_clr(acc_clr), .acc_en(acc_en), .acc(acc)
    );

    // Output side.
    psum_buffer psum_buf_i (
        .clk(clk), .rst(rst),
        .push(push), .psum_in(psum_in), .full(full),
        .psum_valid(psum_valid), .psum_ready(psum_ready), .psum(psum)
    );

endmodule

// ==== tb/conv1d_asserts.sv ====
module conv1d_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_valid,
    input logic                      in_ready,
    input conv_stream_pkg::in_beat_t in_beat,
    input logic                      psum_valid,
    input logic                      psum_ready,
    input conv_stream_pkg::psum_t    psum,
    input logic                      frame_loaded,
    input logic                      frame_done
);

    int fail_count = 0;    // Read by the testbench.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream stalls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    in_stall_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else begin
        fail_count = fail_count + 1;
        $error("input beat dropped or changed while stalled");
    end

    psum_stall_hold: assert property (@(posedge clk) disable iff (rst)
        psum_valid && !psum_ready |=> psum_valid && $stable(psum))
    else begin
        fail_count = fail_count + 1;
        $error("partial sum dropped or changed while stalled");
    end

    // Quiet output through reset and one cycle beyond.
    reset_quiet: assert property (@(posedge clk) rst |=> !psum_valid)
    else begin
        fail_count = fail_count + 1;
        $error("psum_valid high during or right after reset");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    closed_while_busy: assert property (@(posedge clk) disable iff (rst)
        frame_loaded && !frame_done |=> !in_ready)
    else begin
        fail_count = fail_count + 1;
        $error("in_ready rose before frame_done");
    end

    open_after_done: assert property (@(posedge clk) disable iff (rst)
        frame_done |=> in_ready)
    else begin
        fail_count = fail_count + 1;
        $error("in_ready did not rise after frame_done");
    end

endmodule

bind conv1d_top conv1d_asserts asserts_i (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
    .psum_valid(psum_valid), .psum_ready(psum_ready), .psum(psum),
    .frame_loaded(frame_loaded), .frame_done(frame_done)
);

// ==== tb/conv1d_tb.sv ====
module conv1d_tb;

    localparam int FILTER_SIZE = 3;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    conv_stream_pkg::in_beat_t in_beat;
    logic                      psum_valid;
    logic                      psum_ready;
    conv_stream_pkg::psum_t    psum;

    integer                                 seed = 32'h3585b12e;
    logic                                   bp_on;
    int                                     row_len [4];
    logic signed [conv_cfg_pkg::DATA_W-1:0] weights [FILTER_SIZE];
    logic signed [conv_cfg_pkg::DATA_W-1:0] pixels  [32];
    conv_stream_pkg::psum_t                 exp_q [$];
    conv_stream_pkg::psum_t                 expect_beat;

    conv1d_top #(
        .IFMAP_DEPTH(32),
        .MAX_ROW(4),
        .FILTER_SIZE(FILTER_SIZE)
    ) dut_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
        .psum_valid(psum_valid), .psum_ready(psum_ready), .psum(psum)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic send_beat(input conv_cfg_pkg::beat_kind_e kind, input logic last,
                             input conv_cfg_pkg::payload_u payload);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid        = 1'b1;
        in_beat.kind    = kind;
        in_beat.last    = last;
        in_beat.payload = payload;
        @(posedge clk);
        while (!in_ready) begin    // Held while the previous frame computes.
            waited++;
            if (waited > 1000) begin
                abort_run("timed out waiting for an input beat to be accepted");
            end
            @(posedge clk);
        end
    endtask

    // Expected sums straight from the window definition.
    task automatic add_expected(input int stride, input int rows);
        int                     base;
        int                     n;
        longint                 acc;
        conv_stream_pkg::psum_t beat;
        base = 0;
        for (int r = 0; r < rows; r++) begin
            n = (row_len[r] - FILTER_SIZE) / stride + 1;
            for (int p = 0; p < n; p++) begin
                acc = 0;
                for (int k = 0; k < FILTER_SIZE; k++) begin
                    acc += longint'(weights[k]) * longint'(pixels[base + p * stride + k]);
                end
                beat.row = 4'(r);
                beat.sum = 36'(acc);
                exp_q.push_back(beat);
            end
            base += row_len[r];
        end
    endtask

    task automatic load_frame(input int stride, input int rows, input bit extreme);
        int                     base;
        conv_cfg_pkg::payload_u pl;
        base = 0;
        for (int k = 0; k < FILTER_SIZE; k++) begin
            weights[k] = extreme ? 16'sh8000 : 16'($random(seed));
        end
        for (int r = 0; r < rows; r++) begin
            for (int i = 0; i < row_len[r]; i++) begin
                if (extreme) begin
                    pixels[base + i] = (r == 0) ? 16'sh8000 : 16'sh7fff;
                end else begin
                    pixels[base + i] = 16'($random(seed));
                end
            end
            base += row_len[r];
        end
        add_expected(stride, rows);

        pl              = '0;
        pl.cfg.stride   = 4'(stride);
        pl.cfg.num_rows = 4'(rows);
        send_beat(conv_cfg_pkg::KIND_CFG, 1'b0, pl);
        for (int k = 0; k < FILTER_SIZE; k++) begin
            pl.value = weights[k];    // Tap 0 first.
            send_beat(conv_cfg_pkg::KIND_WEIGHT, 1'b0, pl);
        end
        base = 0;
        for (int r = 0; r < rows; r++) begin
            for (int i = 0; i < row_len[r]; i++) begin
                pl.value = pixels[base + i];
                send_beat(conv_cfg_pkg::KIND_PIXEL, i == row_len[r] - 1, pl);
            end
            base += row_len[r];
        end
        @(negedge clk);
        in_valid = 1'b0;
        assert (!in_ready) else abort_run("in_ready still high after the frame was loaded");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        psum_ready = !bp_on || (($random(seed) & 3) != 0);
        if (dut_i.asserts_i.fail_count != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    always @(posedge clk) begin
        if (!rst && psum_valid && psum_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a partial sum arrived that the model did not expect");
            end else begin
                expect_beat = exp_q.pop_front();
                assert (psum.row == expect_beat.row) else abort_run($sformatf(
                    "** Error at time %0t: psum.row expected %0d, actual %0d",
                    $time, expect_beat.row, psum.row));
                assert (psum.sum == expect_beat.sum) else abort_run($sformatf(
                    "** Error at time %0t: psum.sum expected %0d, actual %0d",
                    $time, expect_beat.sum, psum.sum));
            end
        end
    end

    initial begin
        int waited;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_beat    = '0;
        bp_on      = 1'b0;
        psum_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready && !psum_valid) else abort_run("wrong stream state after reset");

        row_len[0] = 8;    // Six windows at stride 1.
        load_frame(1, 1, 1'b0);
        bp_on      = 1'b1;
        row_len[0] = 7;
        row_len[1] = 5;
        row_len[2] = 9;
        load_frame(2, 3, 1'b0);
        row_len[0] = 4;    // Full scale products of both signs.
        row_len[1] = 4;
        load_frame(1, 2, 1'b1);
        row_len[0] = 6;
        row_len[1] = 9;
        load_frame(3, 2, 1'b0);

        waited = 0;
        while (exp_q.size() != 0 || !in_ready || psum_valid) begin
            waited++;
            if (waited > 2000) begin
                abort_run("timed out waiting for the last partial sums");
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (dut_i.asserts_i.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("a bound protocol assertion failed");
        end
    end

endmodule

// ==== compile.f ====
verilog/conv_cfg_pkg.sv
verilog/conv_stream_pkg.sv
verilog/ifmap_loader.sv
verilog/ifmap_spad.sv
verilog/ifmap_addr_gen.sv
verilog/conv_ctrl.sv
verilog/mac_unit.sv
verilog/psum_buffer.sv
verilog/conv1d_top.sv
tb/conv1d_asserts.sv
tb/conv1d_tb.sv

// ==== Bender.yml ====
package:
  name: conv1d

sources:
  - verilog/conv_cfg_pkg.sv
  - verilog/conv_stream_pkg.sv
  - verilog/ifmap_loader.sv
  - verilog/ifmap_spad.sv
  - verilog/ifmap_addr_gen.sv
  - verilog/conv_ctrl.sv
  - verilog/mac_unit.sv
  - verilog/psum_buffer.sv
  - verilog/conv1d_top.sv
  - target: simulation
    files:
      - tb/conv1d_asserts.sv
      - tb/conv1d_tb.sv
